//--- all.f
rtl/drop_pkg.sv
rtl/move_control.sv
rtl/square.sv
rtl/piece_status.sv
rtl/block_drop_top.sv
tb/tb_block_drop.sv

//--- rtl/block_drop_top.sv
module block_drop_top
    import drop_pkg::*;
#(
    parameter logic [9:0] x_min = 10'd200,          // Field left bound
    parameter logic [9:0] x_max = 10'd400,          // Field right bound
    parameter logic [9:0] y_max = 10'd400,          // Field floor
    parameter logic [9:0] step  = 10'd20            // One move that divides the bounds
)
(
    input  logic                   reset,           // Clock
    input  logic                   clk,             // Async reset, active high
    input  logic                   cmd_valid,       // Command strobe from keyboard decoder
    input  cmd_op_t                cmd_op,
    input  shape_t                 cmd_shape,
    input  pos_t                   cmd_center,
    output pos_t [num_squares-1:0] squares,         // To renderer
    output box_t                   box,
    output piece_state_t           state,
    output logic [7:0]             landed_count
);

    move_t                     move;
    wire pos_t  [num_squares-1:0] load_pos;         // Spawn targets
    wire pos_t  [num_squares-1:0] sq_pos;           // Live square positions
    wire edge_t [num_squares-1:0] sq_flags;
    edge_t                     any_edge;
    logic                      landed_pulse;

    assign squares = sq_pos;

    move_control #(
        .step (step)
    ) u_ctrl (
        .reset        (reset),
        .clk          (clk),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_shape    (cmd_shape),
        .cmd_center   (cmd_center),
        .any_edge     (any_edge),
        .move         (move),
        .load_pos     (load_pos),
        .state        (state),
        .landed_pulse (landed_pulse)
    );

    // One position register per square sharing the move strobes
    for (genvar i = 0; i < num_squares; i++)
    begin : g_sq
        square #(
            .x_min (x_min),
            .x_max (x_max),
            .y_max (y_max),
            .step  (step)
        ) u_sq (
            .reset      (reset),
            .clk        (clk),
            .move       (move),
            .load_pos   (load_pos[i]),
            .pos        (sq_pos[i]),
            .edge_flags (sq_flags[i])
        );
    end

    piece_status u_status (
        .reset        (reset),
        .clk          (clk),
        .squares      (sq_pos),
        .flags        (sq_flags),
        .landed_pulse (landed_pulse),
        .box          (box),
        .any_edge     (any_edge),
        .landed_count (landed_count)
    );

endmodule

//--- rtl/drop_pkg.sv
package drop_pkg;

    localparam int num_squares = 4;                 // Squares per piece
    localparam logic [9:0] square_size = 10'd20;    // Edge length in pixels

    // Top-left corner of one square
    typedef struct packed {
        logic [9:0] x;                              // Screen column
        logic [9:0] y;                              // Screen row
    } pos_t;

    // Per-cycle action strobes sent to every square
    typedef struct packed {
        logic load;                                 // Take spawn position
        logic left;                                 // Step x down
        logic right;                                // Step x up
        logic down;                                 // Step y up
    } move_t;

    typedef struct packed {
        logic [9:0] min_x;
        logic [9:0] min_y;
        logic [9:0] max_x;
        logic [9:0] max_y;
    } box_t;

    typedef struct packed {
        logic at_left;                              // At or past x_min
        logic at_right;                             // At or past x_max
        logic at_bottom;                            // At or past y_max
    } edge_t;

    typedef enum logic [1:0] {
        op_spawn = 2'd0,
        op_left  = 2'd1,
        op_right = 2'd2,
        op_down  = 2'd3
    } cmd_op_t;

    typedef enum logic [1:0] {
        shape_o   = 2'd0,                           // 2x2 block
        shape_i   = 2'd1,                           // Straight bar
        shape_tee = 2'd2,                           // T piece
        shape_l   = 2'd3                            // L piece
    } shape_t;

    typedef enum logic [1:0] {
        st_idle    = 2'd0,                          // No piece yet
        st_falling = 2'd1,                          // Piece under control
        st_landed  = 2'd2                           // Piece has settled
    } piece_state_t;

endpackage

//--- rtl/move_control.sv
module move_control
    import drop_pkg::*;
#(
    parameter logic [9:0] step = 10'd20                 // Distance of one move
)
(
    input  logic                   reset,               // Clock
    input  logic                   clk,                 // Async reset, active high
    input  logic                   cmd_valid,           // One-cycle command strobe
    input  cmd_op_t                cmd_op,
    input  shape_t                 cmd_shape,
    input  pos_t                   cmd_center,          // Spawn anchor for square 0
    input  edge_t                  any_edge,            // Edge flags ORed over the piece
    output move_t                  move,                // Strobes to all squares
    output pos_t [num_squares-1:0] load_pos,            // Spawn positions per square
    output piece_state_t           state,
    output logic                   landed_pulse         // One cycle per landing
);

    logic [num_squares-1:0][1:0] off_x;                 // Shape offsets in steps
    logic [num_squares-1:0][1:0] off_y;
    piece_state_t                state_next;
    logic                        land_now;              // Falling piece touches bottom
    logic                        falling;

    assign falling  = (state == st_falling);
    assign land_now = falling && any_edge.at_bottom;

    // Shape table packed as index 3 down to 0
    always_comb
    begin
        case (cmd_shape)
            shape_o:
            begin
                off_x = {2'd1, 2'd0, 2'd1, 2'd0};
                off_y = {2'd1, 2'd1, 2'd0, 2'd0};
            end
            shape_i:
            begin
                off_x = {2'd3, 2'd2, 2'd1, 2'd0};
                off_y = {2'd0, 2'd0, 2'd0, 2'd0};
            end
            shape_tee:
            begin
                off_x = {2'd1, 2'd2, 2'd1, 2'd0};
                off_y = {2'd1, 2'd0, 2'd0, 2'd0};
            end
            default:                                    // shape_l
            begin
                off_x = {2'd1, 2'd0, 2'd0, 2'd0};
                off_y = {2'd2, 2'd2, 2'd1, 2'd0};
            end
        endcase
    end

    // Scale offsets by step around the center
    always_comb
    begin
        for (int i = 0; i < num_squares; i++)
        begin
            load_pos[i].x = cmd_center.x + 10'(off_x[i]) * step;
            load_pos[i].y = cmd_center.y + 10'(off_y[i]) * step;
        end
    end

    // Whole piece moves or nothing does
    always_comb
    begin
        move = '0;
        if (cmd_valid)
        begin
            case (cmd_op)
                op_spawn: move.load  = !falling;        // Only without a live piece
                op_left:  move.left  = falling && !any_edge.at_left;
                op_right: move.right = falling && !any_edge.at_right;
                default:  move.down  = falling && !any_edge.at_bottom;
            endcase
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle, st_landed:
                if (move.load)
                    state_next = st_falling;
            st_falling:
                if (land_now)
                    state_next = st_landed;
            default:
                state_next = st_idle;                   // Unused code
        endcase
    end

    always_ff @(posedge reset or posedge clk)
    begin
        if (clk)
        begin
            state        <= st_idle;
            landed_pulse <= 1'b0;
        end
        else
        begin
            state        <= state_next;
            landed_pulse <= land_now;                   // Aligned with entry to st_landed
        end
    end

endmodule

//--- rtl/piece_status.sv
module piece_status
    import drop_pkg::*;
(
    input  logic                    reset,          // Clock
    input  logic                    clk,            // Async reset, active high
    input  pos_t  [num_squares-1:0] squares,        // Positions of all squares
    input  edge_t [num_squares-1:0] flags,          // Edge flags of all squares
    input  logic                    landed_pulse,   // From control on landing
    output box_t                    box,            // Bounding box of top-left corners
    output edge_t                   any_edge,       // OR of all square flags
    output logic [7:0]              landed_count    // Pieces landed so far
);

    box_t  box_c;
    edge_t edge_c;

    // Seed from square 0 then sweep the rest
    always_comb
    begin
        box_c.min_x = squares[0].x;
        box_c.max_x = squares[0].x;
        box_c.min_y = squares[0].y;
        box_c.max_y = squares[0].y;
        edge_c      = flags[0];
        for (int i = 1; i < num_squares; i++)
        begin
            if (squares[i].x < box_c.min_x)
                box_c.min_x = squares[i].x;
            if (squares[i].x > box_c.max_x)
                box_c.max_x = squares[i].x;
            if (squares[i].y < box_c.min_y)
                box_c.min_y = squares[i].y;
            if (squares[i].y > box_c.max_y)
                box_c.max_y = squares[i].y;
            edge_c.at_left   = edge_c.at_left   | flags[i].at_left;
            edge_c.at_right  = edge_c.at_right  | flags[i].at_right;
            edge_c.at_bottom = edge_c.at_bottom | flags[i].at_bottom;
        end
    end

    assign box      = box_c;
    assign any_edge = edge_c;                       // Fed back for move gating

    // Counter lags the pulse by one edge
    always_ff @(posedge reset or posedge clk)
    begin
        if (clk)
        begin
            landed_count <= 8'd0;
        end
        else if (landed_pulse)
        begin
            landed_count <= landed_count + 8'd1;    // Wraps after 255
        end
    end

endmodule

//--- rtl/square.sv
module square
    import drop_pkg::*;
#(
    parameter logic [9:0] x_min = 10'd200,      // Left field bound
    parameter logic [9:0] x_max = 10'd400,      // Right field bound
    parameter logic [9:0] y_max = 10'd400,      // Floor
    parameter logic [9:0] step  = 10'd20        // Move distance
)
(
    input  logic  reset,                        // Clock
    input  logic  clk,                          // Async reset, active high
    input  move_t move,                         // Strobes from control
    input  pos_t  load_pos,                     // This square's spawn point
    output pos_t  pos,                          // Current top-left corner
    output edge_t edge_flags                    // Own edge contacts
);

    pos_t pos_next;

    // Control never raises more than one strobe at once
    always_comb
    begin
        pos_next = pos;
        if (move.load)
        begin
            pos_next = load_pos;
        end
        else if (move.left)
        begin
            pos_next.x = pos.x - step;
        end
        else if (move.right)
        begin
            pos_next.x = pos.x + step;
        end
        else if (move.down)
        begin
            pos_next.y = pos.y + step;
        end
    end

    always_ff @(posedge reset or posedge clk)
    begin
        if (clk)
        begin
            pos <= '0;                          // Parked at origin
        end
        else
        begin
            pos <= pos_next;
        end
    end

    // Bounds are enforced by control rather than clamped per square
    always_comb
    begin
        edge_flags.at_left   = (pos.x <= x_min);
        edge_flags.at_right  = (pos.x >= x_max);
        edge_flags.at_bottom = (pos.y >= y_max);
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" &&
verilator --binary --timing -f all.f --top-module tb_block_drop -o tb_block_drop &&
./obj_dir/tb_block_drop | tee /dev/stderr | grep -F "** PASS **" > /dev/null &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}

//--- tb/block_drop_patterns.txt
# op(0 spawn 1 left 2 right 3 down) shape(0 O 1 I 2 T 3 L) cx cy
# then expected min_x min_y max_x max_y state(0 idle 1 falling 2 landed) count
1 0   0   0     0   0   0   0  0 0
3 0   0   0     0   0   0   0  0 0
0 0 340 300   340 300 360 320  1 0
0 1 220 200   340 300 360 320  1 0
1 0   0   0   320 300 340 320  1 0
2 0   0   0   340 300 360 320  1 0
2 0   0   0   360 300 380 320  1 0
2 0   0   0   380 300 400 320  1 0
2 0   0   0   380 300 400 320  1 0
3 0   0   0   380 320 400 340  1 0
3 0   0   0   380 340 400 360  1 0
3 0   0   0   380 360 400 380  1 0
3 0   0   0   380 380 400 400  2 1
3 0   0   0   380 380 400 400  2 1
1 0   0   0   380 380 400 400  2 1
0 1 200 340   200 340 260 340  1 1
1 0   0   0   200 340 260 340  1 1
2 0   0   0   220 340 280 340  1 1
3 0   0   0   220 360 280 360  1 1
3 0   0   0   220 380 280 380  1 1
3 0   0   0   220 400 280 400  2 2
0 2 300 340   300 340 340 360  1 2
1 0   0   0   280 340 320 360  1 2
3 0   0   0   280 360 320 380  1 2
3 0   0   0   280 380 320 400  2 3
2 0   0   0   280 380 320 400  2 3
0 3 240 300   240 300 260 340  1 3
0 0 300 200   240 300 260 340  1 3
3 0   0   0   240 320 260 360  1 3
3 0   0   0   240 340 260 380  1 3
3 0   0   0   240 360 260 400  2 4

//--- tb/tb_block_drop.sv
module tb_block_drop
    import drop_pkg::*;
();

    localparam logic [9:0] step = 10'd20;           // Field move distance

    // One line of the pattern file
    typedef struct packed {
        cmd_op_t      op;
        shape_t       shape;
        pos_t         center;
        box_t         box;                          // Expected after settling
        piece_state_t state;
        logic [7:0]   count;
    } pattern_t;

    logic                   reset;                  // Clock
    logic                   clk;                    // Async reset, active high
    logic                   cmd_valid;
    cmd_op_t                cmd_op;
    shape_t                 cmd_shape;
    pos_t                   cmd_center;
    pos_t [num_squares-1:0] squares;
    box_t                   box;
    piece_state_t           state;
    logic [7:0]             landed_count;

    pattern_t     pats[$];                          // Whole stimulus table
    bit           loaded = 1'b0;                    // Releases the watchdog
    bit           file_ok;
    bit           have_piece = 1'b0;                // A spawn has been taken
    shape_t       piece_shape = shape_o;            // Shape of the live piece
    piece_state_t last_state = st_idle;             // Expected state before the command
    int           box_errs = 0;
    int           state_errs = 0;
    int           count_errs = 0;
    int           sq_errs = 0;

    block_drop_top #(
        .x_min (10'd200),
        .x_max (10'd400),
        .y_max (10'd400),
        .step  (step)
    ) uut (
        .reset        (reset),
        .clk          (clk),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_shape    (cmd_shape),
        .cmd_center   (cmd_center),
        .squares      (squares),
        .box          (box),
        .state        (state),
        .landed_count (landed_count)
    );

    always #2 reset = ~reset;                       // Period 4

    // Comment and blank lines fail the scan and are skipped
    task automatic load_patterns(output bit ok);
        int       fd;
        int       r;
        int       v[10];
        string    line;
        pattern_t p;
        ok = 1'b0;
        fd = $fopen("tb/block_drop_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("could not open tb/block_drop_patterns.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                r = $fgets(line, fd);
                if (r > 0)
                begin
                    r = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d", v[0], v[1], v[2],
                                v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                    if (r == 10)
                    begin
                        p.op         = cmd_op_t'(v[0][1:0]);
                        p.shape      = shape_t'(v[1][1:0]);
                        p.center.x   = v[2][9:0];
                        p.center.y   = v[3][9:0];
                        p.box.min_x  = v[4][9:0];
                        p.box.min_y  = v[5][9:0];
                        p.box.max_x  = v[6][9:0];
                        p.box.max_y  = v[7][9:0];
                        p.state      = piece_state_t'(v[8][1:0]);
                        p.count      = v[9][7:0];
                        pats.push_back(p);
                    end
                end
            end
            $fclose(fd);
            if (pats.size() == 0)
                $display("pattern file holds no usable lines");
            else
                ok = 1'b1;
        end
    endtask

    // Square 0 sits at the box corner, the others at table offsets in steps
    function automatic pos_t [num_squares-1:0] shape_squares(input shape_t sh, input box_t b);
        int                     ox[num_squares];
        int                     oy[num_squares];
        pos_t [num_squares-1:0] s;
        case (sh)
            shape_o:
            begin
                ox = '{0, 1, 0, 1};
                oy = '{0, 0, 1, 1};
            end
            shape_i:
            begin
                ox = '{0, 1, 2, 3};
                oy = '{0, 0, 0, 0};
            end
            shape_tee:
            begin
                ox = '{0, 1, 2, 1};
                oy = '{0, 0, 0, 1};
            end
            default:                                // L piece
            begin
                ox = '{0, 0, 0, 1};
                oy = '{0, 1, 2, 2};
            end
        endcase
        for (int i = 0; i < num_squares; i++)
        begin
            s[i].x = b.min_x + 10'(ox[i]) * step;
            s[i].y = b.min_y + 10'(oy[i]) * step;
        end
        return s;
    endfunction

    task automatic check_box(input int idx, input box_t got, input box_t exp);
        string g;
        string e;
        if (got !== exp)
        begin
            box_errs++;
            g = $sformatf("(%0d,%0d)-(%0d,%0d)", got.min_x, got.min_y, got.max_x, got.max_y);
            e = $sformatf("(%0d,%0d)-(%0d,%0d)", exp.min_x, exp.min_y, exp.max_x, exp.max_y);
            $display("mismatch at %0t: pattern %0d box got %s expected %s",
                     $time, idx, g, e);
        end
    endtask

    task automatic check_state(input int idx, input piece_state_t got, input piece_state_t exp);
        if (got !== exp)
        begin
            state_errs++;
            $display("mismatch at %0t: pattern %0d state got %0d expected %0d",
                     $time, idx, got, exp);
        end
    endtask

    task automatic check_count(input int idx, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            count_errs++;
            $display("mismatch at %0t: pattern %0d landed_count got %0d expected %0d",
                     $time, idx, got, exp);
        end
    endtask

    task automatic check_squares(input int idx, input pos_t [num_squares-1:0] got,
                                 input pos_t [num_squares-1:0] exp);
        for (int i = 0; i < num_squares; i++)
        begin
            if (got[i] !== exp[i])
            begin
                sq_errs++;
                $display("mismatch at %0t: pattern %0d squares[%0d] got (%0d,%0d) expected (%0d,%0d)",
                         $time, idx, i, got[i].x, got[i].y, exp[i].x, exp[i].y);
            end
        end
    endtask

    // One strobe, three settling edges, then sample mid-cycle
    task automatic apply_pattern(input int idx);
        pos_t [num_squares-1:0] exp_sq;
        @(posedge reset);
        cmd_valid  <= 1'b1;
        cmd_op     <= pats[idx].op;
        cmd_shape  <= pats[idx].shape;
        cmd_center <= pats[idx].center;
        @(posedge reset);                           // DUT takes the command here
        cmd_valid  <= 1'b0;
        repeat (2) @(posedge reset);                // Landing and count update
        @(negedge reset);
        if (pats[idx].op == op_spawn && last_state != st_falling)
        begin
            have_piece  = 1'b1;                     // Spawn taken outside st_falling
            piece_shape = pats[idx].shape;
        end
        last_state = pats[idx].state;
        if (have_piece)
            exp_sq = shape_squares(piece_shape, pats[idx].box);
        else
            exp_sq = '0;                            // Still parked at reset
        check_box(idx, box, pats[idx].box);
        check_state(idx, state, pats[idx].state);
        check_count(idx, landed_count, pats[idx].count);
        check_squares(idx, squares, exp_sq);
    endtask

    initial
    begin
        reset      = 1'b0;
        clk        = 1'b1;                          // Held in reset
        cmd_valid  = 1'b0;
        cmd_op     = op_spawn;
        cmd_shape  = shape_o;
        cmd_center = '0;
        load_patterns(file_ok);
        loaded = 1'b1;
        if (!file_ok)
        begin
            $display("no stimulus, run aborted");
            $display("** FAIL **");
        end
        else
        begin
            $display("%0d patterns, square size %0d", pats.size(), square_size);
            repeat (8) @(posedge reset);
            clk <= 1'b0;
            for (int i = 0; i < pats.size(); i++)
                apply_pattern(i);
            $display("errors: box %0d state %0d count %0d squares %0d",
                     box_errs, state_errs, count_errs, sq_errs);
            if (box_errs + state_errs + count_errs + sq_errs == 0)
                $display("** PASS **");
            else
                $display("** FAIL **");
        end
        $finish;
    end

    // Four cycles per pattern plus margin for reset
    initial
    begin
        wait (loaded);
        repeat (pats.size() * 5 + 100) @(posedge reset);
        $display("timeout, patterns did not complete in time");
        $display("** FAIL **");
        $finish;
    end

endmodule
